/* bench/pitch_cases.txt */
// half_period amplitude exp_count exp_level, all hex
// One 1024-sample square-wave frame per line, zero half-period ends the list
0008 1f40 007f 0007
0002 1f40 01ff 0010
0008 012c 0000 0001
0004 4000 00ff 000d
0010 0200 003f 0004
0003 7000 0155 0010
0020 01ff 0000 0001
0000 0000 0000 0000

/* filelist.f */
hw/pitch_pkg.sv
hw/i2s_capture.sv
hw/pitch_ctrl.sv
hw/zero_cross_counter.sv
hw/level_mapper.sv
hw/seg_display.sv
hw/pitch_top.sv
bench/pitch_properties.sv
bench/pitch_tb.sv

/* Bender.yml */
package:
  name: pitch_meter

sources:
  - files:
      - hw/pitch_pkg.sv
      - hw/i2s_capture.sv
      - hw/pitch_ctrl.sv
      - hw/zero_cross_counter.sv
      - hw/level_mapper.sv
      - hw/seg_display.sv
      - hw/pitch_top.sv
  - target: test
    files:
      - bench/pitch_properties.sv
      - bench/pitch_tb.sv

/* bench/pitch_tb.sv */
module pitch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pitch_pkg::*;

    localparam int MAX_CASES = 8;            // Lines in the cases file including the sentinel
    localparam int FRAME_TIMEOUT = 600_000;  // Longer than one 524288-cycle frame

    logic             adc_clk = 1'b0;
    logic             rst_n;
    logic             bclk;
    logic             lrclk;
    logic             sdat;
    logic [SEG_W-1:0] hex0;
    logic [SEG_W-1:0] hex1;
    logic [SEG_W-1:0] hex2;
    logic [SEG_W-1:0] hex3;
    logic [17:0]      ledr;
    logic [15:0]      case_mem [0:4*MAX_CASES-1];  // half-period, amplitude, count, level
    int               errors;
    bit               timed_out;

    always #2 adc_clk = ~adc_clk;   // 4 ns period

    pitch_top dut_i (
        .adc_clk     (adc_clk),
        .rst_n       (rst_n),
        .aud_bclk    (bclk),
        .aud_adclrck (lrclk),
        .aud_adcdat  (sdat),
        .hex0        (hex0),
        .hex1        (hex1),
        .hex2        (hex2),
        .hex3        (hex3),
        .ledr        (ledr)
    );

    // Active-low segment codes in gfedcba order
    function automatic logic [SEG_W-1:0] seg_code(input int digit);
        case (digit)
            0:       return 7'h40;
            1:       return 7'h79;
            2:       return 7'h24;
            3:       return 7'h30;
            4:       return 7'h19;
            5:       return 7'h12;
            6:       return 7'h02;
            7:       return 7'h78;
            8:       return 7'h00;
            9:       return 7'h10;
            default: return SEG_BLANK;
        endcase
    endfunction

    // Sign flips of the square wave within one frame
    function automatic int square_flips(input int half_period, input int amplitude);
        int flips;
        flips = 0;
        for (int n = 1; n < FRAME_LEN; n++) begin
            if ((n / half_period) % 2 != ((n - 1) / half_period) % 2) flips++;
        end
        return (amplitude >= ZC_THRESH) ? flips : 0;   // Small tone never leaves the band
    endfunction

    function automatic int expected_level(input int count);
        return (count >= PITCH_FULL_SCALE) ? LEVEL_MAX : count * 15 / PITCH_FULL_SCALE + 1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // One bclk period with the codec shifting on the falling edge
    task automatic send_slot(input logic lr, input logic bit_val);
        @(posedge adc_clk);
        bclk  <= 1'b0;
        lrclk <= lr;
        sdat  <= bit_val;
        repeat (4) @(posedge adc_clk);
        bclk <= 1'b1;                  // DUT takes the bit here
        repeat (3) @(posedge adc_clk);
    endtask

    // Left word after the one-bit delay with noise in every other slot
    task automatic send_sample(input logic [SAMPLE_W-1:0] left);
        logic [31:0] noise;
        noise = $urandom;
        for (int s = 0; s < 32; s++) begin
            if (s >= 1 && s <= SAMPLE_W) send_slot(1'b0, left[SAMPLE_W-s]);
            else send_slot(1'b0, noise[s]);
        end
        noise = $urandom;
        for (int s = 0; s < 32; s++) send_slot(1'b1, noise[s]);   // Right channel
    endtask

    task automatic drive_frames();
        logic [15:0] hp;
        logic [15:0] amp;
        for (int i = 0; i < MAX_CASES && case_mem[4*i] != 0 && !timed_out; i++) begin
            hp  = case_mem[4*i];
            amp = case_mem[4*i+1];
            for (int n = 0; n < FRAME_LEN; n++) begin
                send_sample(((n / hp) % 2 == 0) ? amp : -amp);   // Phase restarts each frame
            end
        end
    endtask

    // ledr[17] flips once per mapped frame
    task automatic wait_result();
        logic start;
        int   cycles;
        start  = ledr[17];
        cycles = 0;
        while (ledr[17] == start && cycles < FRAME_TIMEOUT) begin
            @(negedge adc_clk);
            cycles++;
        end
        if (ledr[17] == start) begin
            timed_out = 1'b1;
            errors++;
            $display("Timeout: no new pitch result within %0d clock cycles", FRAME_TIMEOUT);
        end
    endtask

    task automatic check_frames();
        int cnt;
        int lvl;
        for (int i = 0; i < MAX_CASES && case_mem[4*i] != 0 && !timed_out; i++) begin
            wait_result();
            if (!timed_out) begin
                cnt = case_mem[4*i+2];
                lvl = expected_level(cnt);
                check_value("cases count", cnt, square_flips(case_mem[4*i], case_mem[4*i+1]));
                check_value("cases level", case_mem[4*i+3], lvl);
                check_value("ledr[9:0]", ledr[9:0], cnt);
                check_value("ledr[16:10]", ledr[16:10], 0);
                check_value("hex0", hex0, seg_code(lvl % 10));
                check_value("hex1", hex1, (lvl >= 10) ? seg_code(1) : SEG_BLANK);
                check_value("hex2", hex2, SEG_BLANK);
                check_value("hex3", hex3, SEG_BLANK);
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        bclk      = 1'b0;
        lrclk     = 1'b1;   // Idle in the right half so the first fall starts a word
        sdat      = 1'b0;
        errors    = 0;
        timed_out = 1'b0;
        void'($urandom(32'h2b5b_f128));
        for (int i = 0; i < 4 * MAX_CASES; i++) case_mem[i] = '0;
        $readmemh("bench/pitch_cases.txt", case_mem);

        repeat (5) @(posedge adc_clk);
        rst_n <= 1'b1;
        @(negedge adc_clk);

        // Idle display before any frame
        check_value("ledr", ledr, 0);
        check_value("hex0", hex0, seg_code(1));
        check_value("hex1", hex1, SEG_BLANK);
        check_value("hex2", hex2, SEG_BLANK);
        check_value("hex3", hex3, SEG_BLANK);

        fork
            drive_frames();
            check_frames();
        join

        $display("Errors: %0d check(s), %0d assertion(s)",
                 errors, dut_i.u_ctrl.props_i.fail_count);
        if (errors == 0 && dut_i.u_ctrl.props_i.fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/pitch_properties.sv */
module pitch_properties (
    input logic                          adc_clk,
    input logic                          rst_n,
    input logic                          sample_valid,
    input logic                          frame_end,
    input logic                          map_start,
    input logic                          map_done,
    input logic [pitch_pkg::COUNT_W-1:0] sample_idx
);
    timeunit 1ns;
    timeprecision 100ps;
    import pitch_pkg::*;

    localparam int MAP_LATENCY = DIV_STEPS + 2;   // map_start to map_done

    int fail_count = 0;   // Tally of assertion failures
    int valid_cnt;        // Samples seen in the current frame

    // Own sample count, wraps at the frame length
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            valid_cnt <= 0;
        end else if (sample_valid) begin
            valid_cnt <= (valid_cnt == FRAME_LEN - 1) ? 0 : valid_cnt + 1;
        end
    end

    // Frame ends on the valid of the last sample and nowhere else
    frame_end_on_valid: assert property (@(posedge adc_clk) disable iff (!rst_n)
        frame_end == (sample_valid && (valid_cnt == FRAME_LEN - 1)))
        else begin
            fail_count++;
            $error("frame_end not on the valid of the last sample in a frame");
        end

    start_after_frame: assert property (@(posedge adc_clk) disable iff (!rst_n)
        frame_end |=> map_start ##1 !map_start)
        else begin
            fail_count++;
            $error("map_start not a single pulse after frame_end");
        end

    done_latency: assert property (@(posedge adc_clk) disable iff (!rst_n)
        map_start |-> ##MAP_LATENCY map_done)
        else begin
            fail_count++;
            $error("map_done not %0d cycles after map_start", MAP_LATENCY);
        end

    // Index follows the sample count and wraps before FRAME_LEN
    index_in_range: assert property (@(posedge adc_clk) disable iff (!rst_n)
        int'(sample_idx) == valid_cnt)
        else begin
            fail_count++;
            $error("sample index out of step with the frame position");
        end

endmodule

bind pitch_ctrl pitch_properties props_i (.*);

/* hw/pitch_top.sv */
module pitch_top (
    input  logic                        adc_clk,
    input  logic                        rst_n,
    input  logic                        aud_bclk,      // Codec bit clock, slave mode
    input  logic                        aud_adclrck,   // Codec ADC LR clock
    input  logic                        aud_adcdat,
    output logic [pitch_pkg::SEG_W-1:0] hex0,
    output logic [pitch_pkg::SEG_W-1:0] hex1,
    output logic [pitch_pkg::SEG_W-1:0] hex2,
    output logic [pitch_pkg::SEG_W-1:0] hex3,
    output logic [17:0]                 ledr
);
    import pitch_pkg::*;

    logic signed [SAMPLE_W-1:0] sample;
    logic                       sample_valid;
    logic                       frame_end;
    logic                       map_start;
    logic                       map_done;
    logic                       frame_toggle;
    logic [COUNT_W-1:0]         crossings;   // Last frame's estimate
    logic [LEVEL_W-1:0]         level;

    i2s_capture u_capture (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .bclk         (aud_bclk),
        .lrclk        (aud_adclrck),
        .sdat         (aud_adcdat),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    pitch_ctrl u_ctrl (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .map_done     (map_done),
        .frame_end    (frame_end),
        .map_start    (map_start),
        .frame_toggle (frame_toggle)
    );

    // Stands in for the FFT, one bin-like index per frame
    zero_cross_counter u_zc (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .frame_end    (frame_end),
        .crossings    (crossings)
    );

    level_mapper u_mapper (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .map_start (map_start),
        .crossings (crossings),
        .level     (level),
        .map_done  (map_done)
    );

    seg_display u_display (
        .adc_clk (adc_clk),
        .rst_n   (rst_n),
        .level   (level),
        .hex0    (hex0),
        .hex1    (hex1),
        .hex2    (hex2),
        .hex3    (hex3)
    );

    // Raw count low, spare LEDs dark, result toggle on top
    assign ledr = {frame_toggle, {(17 - COUNT_W){1'b0}}, crossings};

endmodule

/* hw/seg_display.sv */
module seg_display (
    input  logic                          adc_clk,
    input  logic                          rst_n,
    input  logic [pitch_pkg::LEVEL_W-1:0] level,
    output logic [pitch_pkg::SEG_W-1:0]   hex0,
    output logic [pitch_pkg::SEG_W-1:0]   hex1,
    output logic [pitch_pkg::SEG_W-1:0]   hex2,
    output logic [pitch_pkg::SEG_W-1:0]   hex3
);
    import pitch_pkg::*;

    logic       is_teen;   // Level 10 to 16 needs a tens digit
    logic [3:0] ones;

    // Segment order gfedcba, low lights the segment
    function automatic logic [SEG_W-1:0] seg_digit(input logic [3:0] digit);
        case (digit)
            4'd0:    seg_digit = 7'b100_0000;
            4'd1:    seg_digit = 7'b111_1001;
            4'd2:    seg_digit = 7'b010_0100;
            4'd3:    seg_digit = 7'b011_0000;
            4'd4:    seg_digit = 7'b001_1001;
            4'd5:    seg_digit = 7'b001_0010;
            4'd6:    seg_digit = 7'b000_0010;
            4'd7:    seg_digit = 7'b111_1000;
            4'd8:    seg_digit = 7'b000_0000;
            4'd9:    seg_digit = 7'b001_0000;
            default: seg_digit = SEG_BLANK;   // Not a decimal digit
        endcase
    endfunction

    // Level never exceeds 16, so tens is 0 or 1
    assign is_teen = (level >= LEVEL_W'(10));
    assign ones    = is_teen ? 4'(level - LEVEL_W'(10)) : level[3:0];

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            hex0 <= seg_digit(4'd1);   // Matches the mapper's reset level
            hex1 <= SEG_BLANK;
        end else begin
            hex0 <= seg_digit(ones);
            hex1 <= is_teen ? seg_digit(4'd1) : SEG_BLANK;   // Leading zero blanked
        end
    end

    // Upper digits unused
    assign hex2 = SEG_BLANK;
    assign hex3 = SEG_BLANK;

endmodule

/* hw/level_mapper.sv */
module level_mapper (
    input  logic                          adc_clk,
    input  logic                          rst_n,
    input  logic                          map_start,
    input  logic [pitch_pkg::COUNT_W-1:0] crossings,
    output logic [pitch_pkg::LEVEL_W-1:0] level,
    output logic                          map_done
);
    import pitch_pkg::*;

    logic                 busy;      // Division steps in progress
    logic                 finish;    // Quotient ready, result goes out next edge
    logic [STEP_W-1:0]    step_cnt;  // Steps left
    logic                 sat;       // Count at or above full scale

    logic [DIV_STEPS-1:0] cnt_ext;
    logic [DIV_STEPS-1:0] product;   // crossings * 15
    logic [DIV_STEPS-1:0] dvd;       // Dividend, MSB feeds the remainder
    logic [DIV_STEPS-1:0] quo;
    logic [REM_W-1:0]     rem;
    logic [REM_W:0]       trial;     // Remainder with the next dividend bit
    logic [REM_W:0]       diff;
    logic                 fits;      // Divisor goes into the trial remainder

    assign cnt_ext = DIV_STEPS'(crossings);
    assign product = (cnt_ext << 4) - cnt_ext;   // x16 - x, no multiplier

    assign trial = {rem, dvd[DIV_STEPS-1]};
    assign fits  = (trial >= PITCH_FULL_SCALE);
    assign diff  = trial - (REM_W + 1)'(PITCH_FULL_SCALE);

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            finish   <= 1'b0;
            step_cnt <= '0;
            map_done <= 1'b0;
            level    <= LEVEL_W'(1);   // Lowest level until a frame is mapped
        end else begin
            map_done <= 1'b0;
            if (map_start && !busy && !finish) begin   // Ignored while busy
                busy     <= 1'b1;
                step_cnt <= STEP_W'(DIV_STEPS);
            end else if (busy) begin
                step_cnt <= step_cnt - 1'b1;
                if (step_cnt == STEP_W'(1)) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end else if (finish) begin
                finish   <= 1'b0;
                map_done <= 1'b1;
                // Quotient stays below 15 when not saturated
                level    <= sat ? LEVEL_W'(LEVEL_MAX) : quo[LEVEL_W-1:0] + LEVEL_W'(1);
            end
        end
    end

    // Datapath, division runs even when saturated to keep latency fixed
    always_ff @(posedge adc_clk) begin
        if (map_start && !busy && !finish) begin
            sat <= (crossings >= PITCH_FULL_SCALE);
            dvd <= product;
            rem <= '0;
            quo <= '0;
        end else if (busy) begin
            dvd <= dvd << 1;
            quo <= {quo[DIV_STEPS-2:0], fits};
            rem <= fits ? diff[REM_W-1:0] : trial[REM_W-1:0];   // Restore on no fit
        end
    end

endmodule

/* hw/zero_cross_counter.sv */
module zero_cross_counter (
    input  logic                                 adc_clk,
    input  logic                                 rst_n,
    input  logic signed [pitch_pkg::SAMPLE_W-1:0] sample,
    input  logic                                 sample_valid,
    input  logic                                 frame_end,
    output logic        [pitch_pkg::COUNT_W-1:0]  crossings
);
    import pitch_pkg::*;

    logic [1:0]         zc_state;     // Side of the band last reached
    logic [COUNT_W-1:0] count;        // Running count for the current frame
    logic [COUNT_W-1:0] count_next;
    logic               is_pos;
    logic               is_neg;
    logic               crossed;

    // Signed compares against the hysteresis band
    assign is_pos = (sample >= ZC_THRESH);
    assign is_neg = (sample <= -ZC_THRESH);

    // Only a full swing from one side past the opposite threshold counts
    assign crossed = sample_valid &&
                     (((zc_state == ZC_POS) && is_neg) || ((zc_state == ZC_NEG) && is_pos));

    assign count_next = (crossed && (count != '1)) ? count + 1'b1 : count;   // Saturates

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            zc_state  <= ZC_UNKNOWN;
            count     <= '0;
            crossings <= '0;
        end else if (frame_end) begin
            crossings <= count_next;   // Last sample of the frame included
            count     <= '0;
            zc_state  <= ZC_UNKNOWN;   // Next frame starts clean
        end else if (sample_valid) begin
            count <= count_next;
            if (is_pos) begin
                zc_state <= ZC_POS;
            end else if (is_neg) begin
                zc_state <= ZC_NEG;
            end
        end
    end

endmodule

/* hw/pitch_ctrl.sv */
module pitch_ctrl (
    input  logic adc_clk,
    input  logic rst_n,
    input  logic sample_valid,
    input  logic map_done,
    output logic frame_end,
    output logic map_start,
    output logic frame_toggle
);
    import pitch_pkg::*;

    logic [COUNT_W-1:0] sample_idx;   // Position of the next sample in the frame
    logic [ST_W-1:0]    state;
    logic [ST_W-1:0]    state_next;
    logic               last_sample;

    assign last_sample = (sample_idx == COUNT_W'(FRAME_LEN - 1));

    // Coincident with the valid of the 1024th sample
    assign frame_end = sample_valid && last_sample;

    // One cycle wide since ST_MAP always moves on
    assign map_start = (state == ST_MAP);

    // Sample index runs free of the FSM so frame boundaries never slip
    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            sample_idx <= '0;
        end else if (sample_valid) begin
            if (last_sample) begin
                sample_idx <= '0;   // Wrap at FRAME_LEN
            end else begin
                sample_idx <= sample_idx + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_COLLECT: begin
                if (frame_end) state_next = ST_MAP;
            end
            ST_MAP: begin
                state_next = ST_WAIT_DONE;   // Strobe already issued
            end
            ST_WAIT_DONE: begin
                // A frame is far longer than a mapping, so no frame_end lands here
                if (map_done) state_next = ST_COLLECT;
            end
            default: begin
                state_next = ST_COLLECT;     // Recover from an illegal code
            end
        endcase
    end

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            state        <= ST_COLLECT;
            frame_toggle <= 1'b0;
        end else begin
            state <= state_next;
            if (map_done) begin
                frame_toggle <= ~frame_toggle;   // Marks a fresh result on ledr[17]
            end
        end
    end

endmodule

/* hw/i2s_capture.sv */
module i2s_capture (
    input  logic                                 adc_clk,
    input  logic                                 rst_n,
    input  logic                                 bclk,
    input  logic                                 lrclk,
    input  logic                                 sdat,
    output logic signed [pitch_pkg::SAMPLE_W-1:0] sample,
    output logic                                 sample_valid
);
    import pitch_pkg::*;

    logic [1:0] bclk_sync;   // Two-flop synchronizers, [1] is the safe copy
    logic [1:0] lrclk_sync;
    logic [1:0] sdat_sync;
    logic       bclk_prev;   // Previous synced level for edge detect
    logic       lrclk_prev;

    logic bclk_rise;
    logic lrclk_fall;        // Start of the left half-frame
    logic take_bit;

    logic                        active;   // Inside the 16 data bits of the left word
    logic                        skip;     // I2S one-bit delay still pending
    logic [$clog2(SAMPLE_W)-1:0] bit_cnt;
    logic [SAMPLE_W-1:0]         shreg;

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            bclk_sync  <= '0;
            lrclk_sync <= '0;
            sdat_sync  <= '0;
            bclk_prev  <= 1'b0;
            lrclk_prev <= 1'b0;
        end else begin
            bclk_sync  <= {bclk_sync[0], bclk};
            lrclk_sync <= {lrclk_sync[0], lrclk};
            sdat_sync  <= {sdat_sync[0], sdat};   // Same delay as bclk, so bits line up
            bclk_prev  <= bclk_sync[1];
            lrclk_prev <= lrclk_sync[1];
        end
    end

    assign bclk_rise  = bclk_sync[1] & ~bclk_prev;
    assign lrclk_fall = ~lrclk_sync[1] & lrclk_prev;

    // Left channel only, lrclk low; new word start wins over a stray bit edge
    assign take_bit = bclk_rise && active && !skip && !lrclk_sync[1] && !lrclk_fall;

    always_ff @(posedge adc_clk) begin
        if (!rst_n) begin
            active       <= 1'b0;
            skip         <= 1'b0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;                 // Single-cycle strobe
            if (lrclk_fall) begin
                active  <= 1'b1;
                skip    <= 1'b1;                  // First rising bclk is the delay slot
                bit_cnt <= '0;
            end else if (bclk_rise && active && skip && !lrclk_sync[1]) begin
                skip <= 1'b0;
            end else if (take_bit) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == SAMPLE_W - 1) begin
                    active       <= 1'b0;         // Drop any bits past 16
                    sample_valid <= 1'b1;
                end
            end
        end
    end

    // MSB first shift
    always_ff @(posedge adc_clk) begin
        if (take_bit) shreg <= {shreg[SAMPLE_W-2:0], sdat_sync[1]};
    end

    assign sample = shreg;   // Stable while idle between words

endmodule

/* hw/pitch_pkg.sv */
package pitch_pkg;

    // Audio sample and frame
    localparam int SAMPLE_W = 16;           // Left-channel sample width
    localparam int FRAME_LEN = 1024;        // Samples per analysis frame
    localparam int COUNT_W = 10;            // Crossing count and sample index width

    // Zero-crossing hysteresis band
    localparam int ZC_THRESH = 512;         // Signal must pass +/- this level to count

    // Count to level mapping
    localparam int PITCH_FULL_SCALE = 300;  // Count where the level saturates
    localparam int LEVEL_MAX = 16;          // Saturated level
    localparam int LEVEL_W = 5;             // Holds 1 to 16
    localparam int DIV_STEPS = 14;          // Restoring divider iterations, one per dividend bit
    localparam int REM_W = 9;               // Remainder stays below PITCH_FULL_SCALE
    localparam int STEP_W = 4;              // Divider step counter

    // Seven-segment display
    localparam int SEG_W = 7;
    localparam logic [SEG_W-1:0] SEG_BLANK = 7'b111_1111;  // Active low, all off

    // pitch_ctrl FSM encoding
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_COLLECT = 2'd0;     // Counting samples in a frame
    localparam logic [ST_W-1:0] ST_MAP = 2'd1;         // Kick off the mapper
    localparam logic [ST_W-1:0] ST_WAIT_DONE = 2'd2;   // Mapper busy

    // Hysteresis side of the waveform
    localparam logic [1:0] ZC_UNKNOWN = 2'd0;  // No threshold passed yet this frame
    localparam logic [1:0] ZC_POS = 2'd1;
    localparam logic [1:0] ZC_NEG = 2'd2;

endpackage
